// File: ps2_pkg.sv
// Shared types and constants for the PS/2 host port
// Referenced by scoped names from the RTL files

package ps2_pkg;

    // ****************************************
    // Frame layout
    // ****************************************

    // Data bits per frame, sent least significant first
    localparam int DATA_BITS = 8;
    // Host command frame, data plus odd parity bit
    localparam int FRAME_BITS = DATA_BITS + 1;

    // One byte on the wire
    typedef logic [DATA_BITS-1:0] ps2_byte_t;

    // ****************************************
    // State encodings
    // ****************************************

    // Receiver, one device-to-host frame
    typedef enum logic [2:0] {
        RX_IDLE          = 3'h0,
        RX_WAIT_FOR_DATA = 3'h1,
        RX_DATA_IN       = 3'h2,
        RX_PARITY_IN     = 3'h3,
        RX_STOP_IN       = 3'h4
    } rx_state_t;

    // Command transmitter, one host-to-device frame
    typedef enum logic [2:0] {
        TX_IDLE           = 3'h0,
        TX_INITIATE       = 3'h1,
        TX_WAIT_FOR_CLOCK = 3'h2,
        TX_DATA           = 3'h3,
        TX_STOP           = 3'h4,
        TX_ACK            = 3'h5,
        TX_SENT           = 3'h6,
        TX_ERROR          = 3'h7
    } tx_state_t;

    // Link direction tracking
    typedef enum logic [2:0] {
        LINK_IDLE         = 3'h0,
        LINK_DATA_IN      = 3'h1,
        LINK_COMMAND_OUT  = 3'h2,
        LINK_END_TRANSFER = 3'h3,
        LINK_END_DELAYED  = 3'h4
    } link_state_t;

endpackage

// File: ps2_cmd_if.sv
// Host command request and its status
// Top level drives the request, transmitter answers, link controller watches

interface ps2_cmd_if;

    // Byte to send, held stable while send is high
    ps2_pkg::ps2_byte_t command;
    // Request level
    logic send;
    // Status levels, exactly one rises per request
    logic sent;
    logic timed_out;

    modport host (output command, output send, input sent, input timed_out);

    modport transmitter (input command, input send, output sent, output timed_out);

    modport monitor (input command, input send, input sent, input timed_out);

endinterface

// File: ps2_line_sync.sv
// Registers the PS/2 clock and data lines and finds the clock edges
// Edge pulses come two system clocks after the pin changes

module ps2_line_sync
(
    input  logic clk,
    input  logic reset,
    input  logic ps2_clk_in,
    input  logic ps2_dat_in,
    output logic clk_rise,
    output logic clk_fall,
    output logic data
);

    // Registered clock line and its previous sample
    logic clk_q;
    logic clk_last;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Idle bus is high on both lines
            clk_q    <= 1'b1;
            clk_last <= 1'b1;
            data     <= 1'b1;
            clk_rise <= 1'b0;
            clk_fall <= 1'b0;
        end
        else
        begin
            clk_q    <= ps2_clk_in;
            clk_last <= clk_q;
            data     <= ps2_dat_in;
            // One-cycle pulses from the sample pair
            clk_rise <= clk_q & ~clk_last;
            clk_fall <= ~clk_q & clk_last;
        end
    end

endmodule

// File: ps2_data_in.sv
// Receives one device-to-host frame and presents the data byte
// Started by the link controller, pulses received_data_en per byte

module ps2_data_in
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start_receiving,
    input  logic               wait_for_data,
    input  logic               clk_rise,
    input  logic               data,
    output ps2_pkg::ps2_byte_t received_data,
    output logic               received_data_en
);

    localparam int COUNT_W = $clog2(ps2_pkg::DATA_BITS);

    ps2_pkg::rx_state_t state;
    ps2_pkg::rx_state_t next_state;

    logic [COUNT_W-1:0] data_count;
    ps2_pkg::ps2_byte_t shift_reg;

    // ****************************************
    // Receiver FSM
    // ****************************************

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= ps2_pkg::RX_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ps2_pkg::RX_IDLE:
            begin
                // No new frame while the last byte is being announced
                if (wait_for_data && !received_data_en)
                    next_state = ps2_pkg::RX_WAIT_FOR_DATA;
                else if (start_receiving && !received_data_en)
                    next_state = ps2_pkg::RX_DATA_IN;
            end
            ps2_pkg::RX_WAIT_FOR_DATA:
            begin
                // Start bit is data low at a clock rise
                if (!data && clk_rise)
                    next_state = ps2_pkg::RX_DATA_IN;
                else if (!wait_for_data)
                    next_state = ps2_pkg::RX_IDLE;
            end
            ps2_pkg::RX_DATA_IN:
            begin
                if (clk_rise && (data_count == COUNT_W'(ps2_pkg::DATA_BITS - 1)))
                    next_state = ps2_pkg::RX_PARITY_IN;
            end
            ps2_pkg::RX_PARITY_IN:
            begin
                // Parity bit is skipped
                if (clk_rise)
                    next_state = ps2_pkg::RX_STOP_IN;
            end
            ps2_pkg::RX_STOP_IN:
            begin
                if (clk_rise)
                    next_state = ps2_pkg::RX_IDLE;
            end
            default:
                next_state = ps2_pkg::RX_IDLE;
        endcase
    end

    // ****************************************
    // Data path
    // ****************************************

    // Bit counter, cleared outside the data phase
    always_ff @(posedge clk)
    begin
        if (reset || (state != ps2_pkg::RX_DATA_IN))
            data_count <= '0;
        else if (clk_rise)
            data_count <= data_count + 1'b1;
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk)
    begin
        if ((state == ps2_pkg::RX_DATA_IN) && clk_rise)
            shift_reg <= {data, shift_reg[ps2_pkg::DATA_BITS-1:1]};
    end

    // Byte holds until the next frame completes
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            received_data    <= '0;
            received_data_en <= 1'b0;
        end
        else
        begin
            received_data_en <= (state == ps2_pkg::RX_STOP_IN) && clk_rise;
            if ((state == ps2_pkg::RX_STOP_IN) && clk_rise)
                received_data <= shift_reg;
        end
    end

endmodule

// File: ps2_command_out.sv
// Sends one host command frame to the PS/2 device
// Inhibit, request to send, data with odd parity, stop and ack, with time-outs

module ps2_command_out #(
    parameter int INIT_CYCLES       = 5050,
    parameter int CLOCK_WAIT_CYCLES = 750000,
    parameter int TRANSFER_CYCLES   = 100000
)
(
    input  logic clk,
    input  logic reset,
    input  logic clk_rise,
    input  logic clk_fall,
    ps2_cmd_if.transmitter cmd,
    output logic clk_drive_low,
    output logic dat_drive_low,
    output logic dat_out
);

    localparam int INIT_W     = $clog2(INIT_CYCLES + 1);
    localparam int WAIT_W     = $clog2(CLOCK_WAIT_CYCLES + 1);
    localparam int TRANSFER_W = $clog2(TRANSFER_CYCLES + 1);
    localparam int BIT_W      = $clog2(ps2_pkg::FRAME_BITS);

    ps2_pkg::tx_state_t state;
    ps2_pkg::tx_state_t next_state;

    // Data byte with its odd parity bit on top
    logic [ps2_pkg::FRAME_BITS-1:0] frame;
    logic [BIT_W-1:0]               cur_bit;

    logic [INIT_W-1:0]     init_count;
    logic [WAIT_W-1:0]     wait_count;
    logic [TRANSFER_W-1:0] transfer_count;

    logic init_done;
    logic wait_expired;
    logic transfer_expired;
    logic in_transfer;

    assign init_done        = (init_count == INIT_W'(INIT_CYCLES));
    assign wait_expired     = (wait_count == WAIT_W'(CLOCK_WAIT_CYCLES));
    assign transfer_expired = (transfer_count == TRANSFER_W'(TRANSFER_CYCLES));
    // Data, stop and ack share one time limit
    assign in_transfer = (state == ps2_pkg::TX_DATA) || (state == ps2_pkg::TX_STOP) ||
                         (state == ps2_pkg::TX_ACK);

    // ****************************************
    // Transmitter FSM
    // ****************************************

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= ps2_pkg::TX_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ps2_pkg::TX_IDLE:
                if (cmd.send)
                    next_state = ps2_pkg::TX_INITIATE;
            ps2_pkg::TX_INITIATE:
                if (init_done)
                    next_state = ps2_pkg::TX_WAIT_FOR_CLOCK;
            ps2_pkg::TX_WAIT_FOR_CLOCK:
            begin
                // Device takes over the clock
                if (clk_fall)
                    next_state = ps2_pkg::TX_DATA;
                else if (wait_expired)
                    next_state = ps2_pkg::TX_ERROR;
            end
            ps2_pkg::TX_DATA:
            begin
                // Parity bit is the last one out
                if (clk_fall && (cur_bit == BIT_W'(ps2_pkg::DATA_BITS)))
                    next_state = ps2_pkg::TX_STOP;
                else if (transfer_expired)
                    next_state = ps2_pkg::TX_ERROR;
            end
            ps2_pkg::TX_STOP:
            begin
                if (clk_fall)
                    next_state = ps2_pkg::TX_ACK;
                else if (transfer_expired)
                    next_state = ps2_pkg::TX_ERROR;
            end
            ps2_pkg::TX_ACK:
            begin
                if (clk_rise)
                    next_state = ps2_pkg::TX_SENT;
                else if (transfer_expired)
                    next_state = ps2_pkg::TX_ERROR;
            end
            ps2_pkg::TX_SENT,
            ps2_pkg::TX_ERROR:
                if (!cmd.send)
                    next_state = ps2_pkg::TX_IDLE;
            default:
                next_state = ps2_pkg::TX_IDLE;
        endcase
    end

    // ****************************************
    // Counters and frame
    // ****************************************

    // Capture byte and parity while idle
    always_ff @(posedge clk)
    begin
        if (state == ps2_pkg::TX_IDLE)
            frame <= {~(^cmd.command), cmd.command};
    end

    always_ff @(posedge clk)
    begin
        if (reset || (state != ps2_pkg::TX_INITIATE))
            init_count <= '0;
        else if (!init_done)
            init_count <= init_count + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset || (state != ps2_pkg::TX_WAIT_FOR_CLOCK))
            wait_count <= '0;
        else if (!wait_expired)
            wait_count <= wait_count + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset || !in_transfer)
            transfer_count <= '0;
        else if (!transfer_expired)
            transfer_count <= transfer_count + 1'b1;
    end

    // Next bit on every falling edge, stops at the parity index
    always_ff @(posedge clk)
    begin
        if (reset || (state != ps2_pkg::TX_DATA))
            cur_bit <= '0;
        else if (clk_fall && (cur_bit != BIT_W'(ps2_pkg::DATA_BITS)))
            cur_bit <= cur_bit + 1'b1;
    end

    // Status levels, dropped in the cycle after send is seen low
    always_ff @(posedge clk)
    begin
        if (reset || !cmd.send)
        begin
            cmd.sent      <= 1'b0;
            cmd.timed_out <= 1'b0;
        end
        else
        begin
            if (state == ps2_pkg::TX_SENT)
                cmd.sent <= 1'b1;
            if (state == ps2_pkg::TX_ERROR)
                cmd.timed_out <= 1'b1;
        end
    end

    // ****************************************
    // Line drive
    // ****************************************

    assign clk_drive_low = (state == ps2_pkg::TX_INITIATE);
    // Data goes low halfway through the inhibit and holds until the first fall
    assign dat_drive_low = ((state == ps2_pkg::TX_INITIATE) && (init_count >= INIT_CYCLES / 2)) ||
                           (state == ps2_pkg::TX_WAIT_FOR_CLOCK) || (state == ps2_pkg::TX_DATA);
    assign dat_out = (state == ps2_pkg::TX_DATA) ? frame[cur_bit] : 1'b0;

endmodule

// File: ps2_link_ctrl.sv
// Tracks who owns the PS/2 link and steers the receiver
// Tells a spontaneous device byte apart from the answer to a command

module ps2_link_ctrl #(
    parameter int IDLE_CYCLES = 255
)
(
    input  logic clk,
    input  logic reset,
    input  logic clk_rise,
    input  logic data,
    input  logic received_data_en,
    ps2_cmd_if.monitor cmd,
    output logic start_receiving,
    output logic wait_for_data
);

    localparam int IDLE_W = $clog2(IDLE_CYCLES + 1);

    ps2_pkg::link_state_t state;
    ps2_pkg::link_state_t next_state;

    logic [IDLE_W-1:0] idle_count;
    logic              idle_full;
    logic              start_bit;

    assign idle_full = (idle_count == IDLE_W'(IDLE_CYCLES));
    // Data low at a clock rise marks a frame start
    assign start_bit = !data && clk_rise;

    // ****************************************
    // Link FSM
    // ****************************************

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= ps2_pkg::LINK_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ps2_pkg::LINK_IDLE:
            begin
                // Quiet link and a request means a command phase
                if (idle_full && cmd.send)
                    next_state = ps2_pkg::LINK_COMMAND_OUT;
                else if (start_bit)
                    next_state = ps2_pkg::LINK_DATA_IN;
            end
            ps2_pkg::LINK_DATA_IN:
                if (received_data_en)
                    next_state = ps2_pkg::LINK_IDLE;
            ps2_pkg::LINK_COMMAND_OUT:
                if (cmd.sent || cmd.timed_out)
                    next_state = ps2_pkg::LINK_END_TRANSFER;
            ps2_pkg::LINK_END_TRANSFER:
            begin
                // Device may answer while the request is still up
                if (!cmd.send)
                    next_state = ps2_pkg::LINK_IDLE;
                else if (start_bit)
                    next_state = ps2_pkg::LINK_END_DELAYED;
            end
            ps2_pkg::LINK_END_DELAYED:
                if (received_data_en)
                    next_state = cmd.send ? ps2_pkg::LINK_END_TRANSFER : ps2_pkg::LINK_IDLE;
            default:
                next_state = ps2_pkg::LINK_IDLE;
        endcase
    end

    // Quiet time counter, saturating
    always_ff @(posedge clk)
    begin
        if (reset || (state != ps2_pkg::LINK_IDLE))
            idle_count <= '0;
        else if (!idle_full)
            idle_count <= idle_count + 1'b1;
    end

    assign start_receiving = (state == ps2_pkg::LINK_DATA_IN);
    assign wait_for_data   = (state == ps2_pkg::LINK_END_TRANSFER);

endmodule

// File: ps2_host.sv
// PS/2 host port top level
// Receives device bytes and sends one-byte commands over open-drain lines

module ps2_host #(
    parameter int INIT_CYCLES       = 5050,
    parameter int CLOCK_WAIT_CYCLES = 750000,
    parameter int TRANSFER_CYCLES   = 100000,
    parameter int IDLE_CYCLES       = 255
)
(
    input  logic               clk,
    input  logic               reset,
    input  ps2_pkg::ps2_byte_t command,
    input  logic               send_command,
    inout  wire                ps2_clk,
    inout  wire                ps2_dat,
    output logic               command_was_sent,
    output logic               command_timed_out,
    output ps2_pkg::ps2_byte_t received_data,
    output logic               received_data_en
);

    logic clk_rise;
    logic clk_fall;
    logic data;
    logic start_receiving;
    logic wait_for_data;
    logic clk_drive_low;
    logic dat_drive_low;
    logic dat_out;

    ps2_cmd_if cmd_bus ();

    // Request in, status out, no added cycles
    assign cmd_bus.command   = command;
    assign cmd_bus.send      = send_command;
    assign command_was_sent  = cmd_bus.sent;
    assign command_timed_out = cmd_bus.timed_out;

    // Open drain, lines float high when released
    assign ps2_clk = clk_drive_low ? 1'b0 : 1'bz;
    assign ps2_dat = (dat_drive_low && !dat_out) ? 1'b0 : 1'bz;

    ps2_line_sync u_line_sync (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk_in (ps2_clk),
        .ps2_dat_in (ps2_dat),
        .clk_rise   (clk_rise),
        .clk_fall   (clk_fall),
        .data       (data)
    );

    ps2_data_in u_data_in (
        .clk              (clk),
        .reset            (reset),
        .start_receiving  (start_receiving),
        .wait_for_data    (wait_for_data),
        .clk_rise         (clk_rise),
        .data             (data),
        .received_data    (received_data),
        .received_data_en (received_data_en)
    );

    ps2_command_out #(
        .INIT_CYCLES       (INIT_CYCLES),
        .CLOCK_WAIT_CYCLES (CLOCK_WAIT_CYCLES),
        .TRANSFER_CYCLES   (TRANSFER_CYCLES)
    ) u_command_out (
        .clk           (clk),
        .reset         (reset),
        .clk_rise      (clk_rise),
        .clk_fall      (clk_fall),
        .cmd           (cmd_bus.transmitter),
        .clk_drive_low (clk_drive_low),
        .dat_drive_low (dat_drive_low),
        .dat_out       (dat_out)
    );

    ps2_link_ctrl #(
        .IDLE_CYCLES (IDLE_CYCLES)
    ) u_link_ctrl (
        .clk              (clk),
        .reset            (reset),
        .clk_rise         (clk_rise),
        .data             (data),
        .received_data_en (received_data_en),
        .cmd              (cmd_bus.monitor),
        .start_receiving  (start_receiving),
        .wait_for_data    (wait_for_data)
    );

endmodule

// File: ps2_host_sva.sv
// Protocol assertions for the PS/2 host port
// Bound into ps2_host so every instance is checked

module ps2_host_sva #(
    parameter int INIT_CYCLES = 5050
)
(
    input logic clk,
    input logic reset,
    input logic sent,
    input logic timed_out,
    input logic received_data_en,
    input logic clk_drive_low
);

    timeunit 1ns;
    timeprecision 100ps;

    // Failed assertions so far
    int error_count = 0;
    // Consecutive inhibit cycles before this one
    int inhibit_count;

    always_ff @(posedge clk)
    begin
        if (reset || !clk_drive_low)
            inhibit_count <= 0;
        else
            inhibit_count <= inhibit_count + 1;
    end

    // One outcome per request
    assert property (@(posedge clk) disable iff (reset) !(sent && timed_out))
    else
    begin
        $error("command sent and timed out at the same time");
        error_count++;
    end

    assert property (@(posedge clk) disable iff (reset) received_data_en |=> !received_data_en)
    else
    begin
        $error("received_data_en held for two cycles");
        error_count++;
    end

    // Clock only pulled low for the inhibit length
    assert property (@(posedge clk) disable iff (reset)
                     clk_drive_low |-> (inhibit_count <= INIT_CYCLES))
    else
    begin
        $error("PS/2 clock held low past the inhibit period");
        error_count++;
    end

    assert property (@(posedge clk) disable iff (reset) clk_drive_low |-> !(sent || timed_out))
    else
    begin
        $error("PS/2 clock driven low after the command finished");
        error_count++;
    end

endmodule

bind ps2_host ps2_host_sva #(
    .INIT_CYCLES (INIT_CYCLES)
) sva0 (
    .clk              (clk),
    .reset            (reset),
    .sent             (command_was_sent),
    .timed_out        (command_timed_out),
    .received_data_en (received_data_en),
    .clk_drive_low    (clk_drive_low)
);

// File: tb_ps2_host.sv
// Directed testbench for the PS/2 host port
// Models a PS/2 device on open-drain lines and checks both transfer directions

module tb_ps2_host;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int INIT_CYCLES       = 64;
    localparam int CLOCK_WAIT_CYCLES = 400;
    localparam int TRANSFER_CYCLES   = 2000;
    localparam int IDLE_CYCLES       = 16;
    // Device clock is 40 system clocks per bit
    localparam int QUARTER = 10;
    localparam int SEED    = 40657;

    logic               clk;
    logic               reset;
    ps2_pkg::ps2_byte_t command;
    logic               send_command;
    tri1                ps2_clk;
    tri1                ps2_dat;
    logic               command_was_sent;
    logic               command_timed_out;
    ps2_pkg::ps2_byte_t received_data;
    logic               received_data_en;

    // Device side of the open-drain lines
    logic dev_clk_low;
    logic dev_dat_low;

    // Announced bytes seen so far
    int                 rx_count = 0;
    ps2_pkg::ps2_byte_t rx_byte;

    assign ps2_clk = dev_clk_low ? 1'b0 : 1'bz;
    assign ps2_dat = dev_dat_low ? 1'b0 : 1'bz;

    ps2_host #(
        .INIT_CYCLES       (INIT_CYCLES),
        .CLOCK_WAIT_CYCLES (CLOCK_WAIT_CYCLES),
        .TRANSFER_CYCLES   (TRANSFER_CYCLES),
        .IDLE_CYCLES       (IDLE_CYCLES)
    ) dut0 (
        .clk               (clk),
        .reset             (reset),
        .command           (command),
        .send_command      (send_command),
        .ps2_clk           (ps2_clk),
        .ps2_dat           (ps2_dat),
        .command_was_sent  (command_was_sent),
        .command_timed_out (command_timed_out),
        .received_data     (received_data),
        .received_data_en  (received_data_en)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Byte monitor on the stable half of the cycle
    always @(negedge clk)
    begin
        if (!reset && received_data_en)
        begin
            rx_count = rx_count + 1;
            rx_byte  = received_data;
        end
    end

    // ****************************************
    // Reporting and waiting
    // ****************************************

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic signal_value(input string name);
        if (name == "command_was_sent")
            return command_was_sent;
        else if (name == "command_timed_out")
            return command_timed_out;
        else if (name == "ps2_clk")
            return ps2_clk;
        else
            return ps2_dat;
    endfunction

    // Polls at falling edges until the level shows up
    task automatic wait_level(input string name, input logic level, input int limit);
        int n;
        n = 0;
        while (signal_value(name) !== level)
        begin
            @(negedge clk);
            n++;
            if (n > limit)
                fail_run($sformatf("Timed out after %0d cycles waiting for %s to become %0b",
                                   limit, name, level));
        end
    endtask

    task automatic wait_bytes(input int target, input int limit);
        int n;
        n = 0;
        while (rx_count < target)
        begin
            @(posedge clk);
            n++;
            if (n > limit)
                fail_run("No received_data_en pulse came for the frame the device sent");
        end
        @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // ****************************************
    // PS/2 device model
    // ****************************************

    // Clock low phase then rise, line sampled just before the rise
    task automatic pulse_device_clock(output logic sampled);
        dev_clk_low = 1'b1;
        idle_cycles(2 * QUARTER);
        sampled     = ps2_dat;
        dev_clk_low = 1'b0;
        idle_cycles(QUARTER);
    endtask

    // Start, 8 data LSB first, odd parity, stop
    task automatic send_device_frame(input ps2_pkg::ps2_byte_t value);
        logic [10:0] frame;
        logic        line_bit;
        frame = {1'b1, ~(^value), value, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            dev_dat_low = !frame[i];
            idle_cycles(QUARTER);
            pulse_device_clock(line_bit);
            // Host leaves the data line to the device
            check_value("ps2_dat during device frame", line_bit, frame[i]);
        end
        dev_dat_low = 1'b0;
    endtask

    // Inhibit and request to send, then clock in up to 9 bits
    // Stop and ack only when all 11 clocks are asked for
    task automatic capture_host_frame(input int clocks, output logic [8:0] bits);
        logic sampled;
        bits = '0;
        wait_level("ps2_clk", 1'b0, 20);
        wait_level("ps2_clk", 1'b1, INIT_CYCLES + 20);
        check_value("ps2_dat at request to send", ps2_dat, 1'b0);
        idle_cycles(QUARTER);
        for (int i = 0; (i < clocks) && (i < 9); i++)
        begin
            pulse_device_clock(sampled);
            bits[i] = sampled;
            idle_cycles(QUARTER);
        end
        if (clocks > 9)
        begin
            // Host lets go of the data line for stop
            pulse_device_clock(sampled);
            check_value("ps2_dat at stop bit", sampled, 1'b1);
            idle_cycles(QUARTER);
            // Ack held low across one clock
            dev_dat_low = 1'b1;
            idle_cycles(QUARTER);
            pulse_device_clock(sampled);
            dev_dat_low = 1'b0;
        end
    endtask

    // ****************************************
    // Directed tests
    // ****************************************

    task automatic check_reset_state();
        check_value("command_was_sent", command_was_sent, 1'b0);
        check_value("command_timed_out", command_timed_out, 1'b0);
        check_value("received_data_en", received_data_en, 1'b0);
        check_value("received_data", received_data, 8'h00);
        check_value("ps2_clk", ps2_clk, 1'b1);
        check_value("ps2_dat", ps2_dat, 1'b1);
    endtask

    task automatic receive_byte(input ps2_pkg::ps2_byte_t value);
        int target;
        target = rx_count + 1;
        send_device_frame(value);
        wait_bytes(target, 100);
        // Quiet time so a second pulse would be counted
        idle_cycles(40);
        check_value("received_data_en pulse count", rx_count, target);
        check_value("received_data", rx_byte, value);
    endtask

    task automatic receive_random_bytes(input int count);
        for (int i = 0; i < count; i++)
            receive_byte(ps2_pkg::ps2_byte_t'($urandom));
    endtask

    // Leaves send_command high with the command acknowledged
    task automatic send_one_command(input ps2_pkg::ps2_byte_t value);
        logic [8:0] bits;
        command      = value;
        send_command = 1'b1;
        capture_host_frame(11, bits);
        check_value("command byte at device", bits[7:0], value);
        check_value("command frame parity", ^bits, 1'b1);
        wait_level("command_was_sent", 1'b1, 100);
        check_value("command_timed_out", command_timed_out, 1'b0);
    endtask

    task automatic drop_request(input string status);
        send_command = 1'b0;
        wait_level(status, 1'b0, 4);
        idle_cycles(40);
    endtask

    task automatic answer_after_command(input ps2_pkg::ps2_byte_t value);
        send_one_command(value);
        receive_byte(8'hFA);
        check_value("command_was_sent", command_was_sent, 1'b1);
        drop_request("command_was_sent");
    endtask

    task automatic no_clock_timeout(input ps2_pkg::ps2_byte_t value);
        int n;
        n            = 0;
        command      = value;
        send_command = 1'b1;
        while (command_timed_out !== 1'b1)
        begin
            @(negedge clk);
            check_value("command_was_sent", command_was_sent, 1'b0);
            n++;
            if (n > INIT_CYCLES + CLOCK_WAIT_CYCLES + 100)
                fail_run("command_timed_out never rose while the device stayed silent");
        end
        check_value("ps2_clk", ps2_clk, 1'b1);
        check_value("ps2_dat", ps2_dat, 1'b1);
        drop_request("command_timed_out");
    endtask

    task automatic stalled_transfer(input ps2_pkg::ps2_byte_t value);
        logic [8:0] bits;
        command      = value;
        send_command = 1'b1;
        capture_host_frame(4, bits);
        check_value("first bits at device", bits[3:0], value[3:0]);
        wait_level("command_timed_out", 1'b1, TRANSFER_CYCLES + 100);
        check_value("command_was_sent", command_was_sent, 1'b0);
        check_value("ps2_clk", ps2_clk, 1'b1);
        check_value("ps2_dat", ps2_dat, 1'b1);
        drop_request("command_timed_out");
    endtask

    initial
    begin
        void'($urandom(SEED));
        reset        = 1'b1;
        command      = '0;
        send_command = 1'b0;
        dev_clk_low  = 1'b0;
        dev_dat_low  = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        check_reset_state();
        // Link must be quiet long enough for a command phase
        idle_cycles(IDLE_CYCLES + 8);
        receive_random_bytes(4);
        send_one_command(ps2_pkg::ps2_byte_t'($urandom));
        drop_request("command_was_sent");
        send_one_command(8'hF4);
        drop_request("command_was_sent");
        answer_after_command(8'hFF);
        no_clock_timeout(ps2_pkg::ps2_byte_t'($urandom));
        stalled_transfer(8'hED);
        receive_random_bytes(2);
        if (dut0.sva0.error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: project.f
ps2_pkg.sv
ps2_cmd_if.sv
ps2_line_sync.sv
ps2_data_in.sv
ps2_command_out.sv
ps2_link_ctrl.sv
ps2_host.sv
ps2_host_sva.sv
tb_ps2_host.sv
